// ==== hw/ec_pkg.sv ====
// EC point multiplication shared definitions
// Field element, Jacobian point, multiplier tag and modular add/subtract
`default_nettype none

package ec_pkg;

  localparam int FIELD_W = 16;

  typedef logic [FIELD_W-1:0] fe_t;

  // Jacobian point, z of zero is the point at infinity
  typedef struct packed {
    fe_t x;
    fe_t y;
    fe_t z;
  } jpoint_t;

  // Requester tag carried with every multiply
  typedef logic mtag_t;

  localparam mtag_t TAG_DBL = 1'b0;
  localparam mtag_t TAG_ADD = 1'b1;

  function automatic fe_t fe_add(fe_t a, fe_t b, fe_t p);
    logic [FIELD_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, p})
      s = s - {1'b0, p};
    return s[FIELD_W-1:0];
  endfunction

  // Wraps through 2^FIELD_W, adding p back lands in range
  function automatic fe_t fe_sub(fe_t a, fe_t b, fe_t p);
    fe_t d;
    d = a - b;
    if (a < b)
      d = d + p;
    return d;
  endfunction

endpackage

`default_nettype wire

// ==== hw/mod_mult_if.sv ====
// Modular multiply channel
// One tagged operand pair in, one tagged product out, each with val/rdy
`timescale 1ns/1ns
`default_nettype none

interface mod_mult_if
  import ec_pkg::*;
();
  logic  req_val;
  logic  req_rdy;
  fe_t   a;
  fe_t   b;
  mtag_t req_tag;
  logic  rsp_val;
  logic  rsp_rdy;
  fe_t   rsp_dat;
  mtag_t rsp_tag;

  modport requester (
    output req_val, a, b, req_tag, rsp_rdy,
    input  req_rdy, rsp_val, rsp_dat, rsp_tag
  );

  modport server (
    input  req_val, a, b, req_tag, rsp_rdy,
    output req_rdy, rsp_val, rsp_dat, rsp_tag
  );
endinterface

`default_nettype wire

// ==== hw/mod_mult.sv ====
// Bit-serial modular multiplier
// Shift-and-add over b MSB first, one bit per cycle, result below P_MOD
`timescale 1ns/1ns
`default_nettype none

module mod_mult
  import ec_pkg::*;
#(
  parameter int  W     = FIELD_W,
  parameter fe_t P_MOD = fe_t'(65521)
) (
  input  logic            i_clk,
  input  logic            i_rst,
  mod_mult_if.server      i_mm
);
  localparam int CW = $clog2(W + 2);
  localparam logic [FIELD_W+1:0] P1 = {2'b00, P_MOD};
  localparam logic [FIELD_W+1:0] P2 = {1'b0, P_MOD, 1'b0};

  typedef enum logic [1:0] {MM_IDLE, MM_CALC, MM_RSP} mm_state_t;

  mm_state_t          state;
  logic [CW-1:0]      cnt;
  fe_t                a_q;
  fe_t                b_q;
  fe_t                acc;
  mtag_t              tag_q;
  logic [FIELD_W+1:0] sum;
  logic [FIELD_W+1:0] red;

  assign i_mm.req_rdy = (state == MM_IDLE);
  assign i_mm.rsp_val = (state == MM_RSP);
  assign i_mm.rsp_dat = acc;
  assign i_mm.rsp_tag = tag_q;

  // 2*acc + a stays below 3P, so two subtractions cover it
  always_comb begin
    sum = {1'b0, acc, 1'b0} + (b_q[FIELD_W-1] ? {2'b00, a_q} : '0);
    if (sum >= P2)
      red = sum - P2;
    else if (sum >= P1)
      red = sum - P1;
    else
      red = sum;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= MM_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        MM_IDLE: begin
          cnt <= '0;
          if (i_mm.req_val)
            state <= MM_CALC;
        end
        // Two spare counts after the last bit give the fixed W+2 latency
        MM_CALC: begin
          cnt <= cnt + 1'b1;
          if (cnt == CW'(W + 1))
            state <= MM_RSP;
        end
        default: begin
          if (i_mm.rsp_rdy)
            state <= MM_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_mm.req_val && i_mm.req_rdy) begin
      a_q   <= i_mm.a;
      b_q   <= i_mm.b;
      tag_q <= i_mm.req_tag;
      acc   <= '0;
    end else if (state == MM_CALC && cnt < CW'(W)) begin
      acc <= red[FIELD_W-1:0];
      b_q <= b_q << 1;
    end
  end

  a_operands_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_mm.req_val && i_mm.req_rdy) |-> (i_mm.a < P_MOD && i_mm.b < P_MOD))
    else $error("mod_mult operand not reduced below P_MOD");

endmodule

`default_nettype wire

// ==== hw/mult_arbiter.sv ====
// Round-robin share of one modular multiplier between doubler and adder
// Grants combinationally while the core is idle, returns responses by tag
`timescale 1ns/1ns
`default_nettype none

module mult_arbiter
  import ec_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst,
  mod_mult_if.server    i_req0,
  mod_mult_if.server    i_req1,
  mod_mult_if.requester o_core
);
  mtag_t      prio;
  mtag_t      sel;
  logic [1:0] pending;

  always_comb begin
    if (i_req0.req_val && i_req1.req_val)
      sel = prio;
    else
      sel = i_req1.req_val;
  end

  assign o_core.req_val = i_req0.req_val | i_req1.req_val;
  assign o_core.a       = (sel == TAG_ADD) ? i_req1.a : i_req0.a;
  assign o_core.b       = (sel == TAG_ADD) ? i_req1.b : i_req0.b;
  assign o_core.req_tag = (sel == TAG_ADD) ? i_req1.req_tag : i_req0.req_tag;
  assign i_req0.req_rdy = o_core.req_rdy && (sel == TAG_DBL);
  assign i_req1.req_rdy = o_core.req_rdy && (sel == TAG_ADD);

  // Response side follows the tag that came back with the product
  assign i_req0.rsp_val = o_core.rsp_val && (o_core.rsp_tag == TAG_DBL);
  assign i_req1.rsp_val = o_core.rsp_val && (o_core.rsp_tag == TAG_ADD);
  assign i_req0.rsp_dat = o_core.rsp_dat;
  assign i_req1.rsp_dat = o_core.rsp_dat;
  assign i_req0.rsp_tag = o_core.rsp_tag;
  assign i_req1.rsp_tag = o_core.rsp_tag;
  assign o_core.rsp_rdy = (o_core.rsp_tag == TAG_ADD) ? i_req1.rsp_rdy : i_req0.rsp_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio    <= TAG_DBL;
      pending <= '0;
    end else begin
      if (o_core.rsp_val && o_core.rsp_rdy)
        pending[o_core.rsp_tag] <= 1'b0;
      if (o_core.req_val && o_core.req_rdy) begin
        prio                    <= ~sel;
        pending[o_core.req_tag] <= 1'b1;
      end
    end
  end

  // Each point block waits for its product before asking again
  a_one_per_requester: assert property (@(posedge i_clk) disable iff (i_rst)
    o_core.req_val |-> !pending[o_core.req_tag])
    else $error("multiply request while the same requester has a product pending");

endmodule

`default_nettype wire

// ==== hw/point_dbl.sv ====
// Jacobian point doubling for a = 0
// Seven sequential multiplies on the shared multiplier, infinity passes through
`timescale 1ns/1ns
`default_nettype none

module point_dbl
  import ec_pkg::*;
#(
  parameter fe_t P_MOD = fe_t'(65521)
) (
  input  logic          i_clk,
  input  logic          i_rst,
  input  jpoint_t       i_p,
  input  logic          i_val,
  output logic          o_rdy,
  output jpoint_t       o_p,
  output logic          o_val,
  input  logic          i_rdy,
  mod_mult_if.requester o_mm
);
  typedef enum logic [1:0] {DBL_IDLE, DBL_REQ, DBL_RSP, DBL_DONE} dbl_state_t;

  dbl_state_t state;
  logic [2:0] step;
  jpoint_t    p_q;
  jpoint_t    res_q;
  fe_t        a_r, b_r, c_r, d_r, e_r;
  fe_t        op_a;
  fe_t        r;
  fe_t        c2, c4, c8;
  fe_t        t_acb;

  assign o_rdy        = (state == DBL_IDLE);
  assign o_val        = (state == DBL_DONE);
  assign o_p          = res_q;
  assign o_mm.req_val = (state == DBL_REQ);
  assign o_mm.req_tag = TAG_DBL;
  assign o_mm.rsp_rdy = (state == DBL_RSP);
  assign o_mm.a       = op_a;
  assign r            = o_mm.rsp_dat;

  assign c2    = fe_add(c_r, c_r, P_MOD);
  assign c4    = fe_add(c2, c2, P_MOD);
  assign c8    = fe_add(c4, c4, P_MOD);
  assign t_acb = fe_sub(fe_sub(r, a_r, P_MOD), c_r, P_MOD);

  // Steps: X^2, Y^2, B^2, (X+B)^2, Y*Z, E^2, E*(D-X3)
  always_comb begin
    case (step)
      3'd0:    op_a = p_q.x;
      3'd1:    op_a = p_q.y;
      3'd2:    op_a = b_r;
      3'd3:    op_a = fe_add(p_q.x, b_r, P_MOD);
      3'd4:    op_a = p_q.y;
      default: op_a = e_r;
    endcase
  end

  assign o_mm.b = (step == 3'd4) ? p_q.z :
                  (step == 3'd6) ? fe_sub(d_r, res_q.x, P_MOD) : op_a;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= DBL_IDLE;
      step  <= '0;
    end else begin
      case (state)
        DBL_IDLE: begin
          step <= '0;
          if (i_val)
            state <= (i_p.z == '0) ? DBL_DONE : DBL_REQ;
        end
        DBL_REQ: begin
          if (o_mm.req_rdy)
            state <= DBL_RSP;
        end
        DBL_RSP: begin
          if (o_mm.rsp_val) begin
            step  <= step + 1'b1;
            state <= (step == 3'd6) ? DBL_DONE : DBL_REQ;
          end
        end
        default: begin
          if (i_rdy)
            state <= DBL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == DBL_IDLE && i_val) begin
      p_q   <= i_p;
      res_q <= i_p;
    end else if (state == DBL_RSP && o_mm.rsp_val) begin
      case (step)
        3'd0: begin
          a_r <= r;
          e_r <= fe_add(fe_add(r, r, P_MOD), r, P_MOD);
        end
        3'd1:    b_r <= r;
        3'd2:    c_r <= r;
        3'd3:    d_r <= fe_add(t_acb, t_acb, P_MOD);
        3'd4:    res_q.z <= fe_add(r, r, P_MOD);
        3'd5:    res_q.x <= fe_sub(r, fe_add(d_r, d_r, P_MOD), P_MOD);
        default: res_q.y <= fe_sub(r, c8, P_MOD);
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/point_add.sv ====
// Full Jacobian point addition
// Sixteen sequential multiplies, infinity inputs and P + (-P) handled directly
`timescale 1ns/1ns
`default_nettype none

module point_add
  import ec_pkg::*;
#(
  parameter fe_t P_MOD = fe_t'(65521)
) (
  input  logic          i_clk,
  input  logic          i_rst,
  input  jpoint_t       i_p1,
  input  jpoint_t       i_p2,
  input  logic          i_val,
  output logic          o_rdy,
  output jpoint_t       o_p,
  output logic          o_val,
  input  logic          i_rdy,
  mod_mult_if.requester o_mm
);
  typedef enum logic [1:0] {ADD_IDLE, ADD_REQ, ADD_RSP, ADD_DONE} add_state_t;

  add_state_t state;
  logic [3:0] step;
  jpoint_t    p1_q, p2_q, res_q;
  fe_t        z1s, z2s, z1c, z2c, u1, u2, s1;
  fe_t        h, rr, h2, h3, u1h2, tmp;
  fe_t        op_a, op_b, r, h_n, r_n;

  assign o_rdy        = (state == ADD_IDLE);
  assign o_val        = (state == ADD_DONE);
  assign o_p          = res_q;
  assign o_mm.req_val = (state == ADD_REQ);
  assign o_mm.req_tag = TAG_ADD;
  assign o_mm.rsp_rdy = (state == ADD_RSP);
  assign o_mm.a       = op_a;
  assign o_mm.b       = op_b;
  assign r            = o_mm.rsp_dat;

  // H and R, valid while the step 7 product S2 is on the response
  assign h_n = fe_sub(u2, u1, P_MOD);
  assign r_n = fe_sub(r, s1, P_MOD);

  always_comb begin
    case (step)
      4'd0, 4'd4, 4'd14: op_a = p1_q.z;
      4'd1, 4'd5:        op_a = p2_q.z;
      4'd2:              op_a = p1_q.x;
      4'd3:              op_a = p2_q.x;
      4'd6:              op_a = p1_q.y;
      4'd7:              op_a = p2_q.y;
      4'd10:             op_a = u1;
      4'd11, 4'd12:      op_a = rr;
      4'd13:             op_a = s1;
      default:           op_a = h;
    endcase
    case (step)
      4'd2, 4'd5:  op_b = z2s;
      4'd3, 4'd4:  op_b = z1s;
      4'd6:        op_b = z2c;
      4'd7:        op_b = z1c;
      4'd9, 4'd10: op_b = h2;
      4'd12:       op_b = fe_sub(u1h2, res_q.x, P_MOD);
      4'd13:       op_b = h3;
      4'd14:       op_b = p2_q.z;
      4'd15:       op_b = tmp;
      default:     op_b = op_a;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ADD_IDLE;
      step  <= '0;
    end else begin
      case (state)
        ADD_IDLE: begin
          step <= '0;
          if (i_val)
            state <= (i_p1.z == '0 || i_p2.z == '0) ? ADD_DONE : ADD_REQ;
        end
        ADD_REQ: begin
          if (o_mm.req_rdy)
            state <= ADD_RSP;
        end
        ADD_RSP: begin
          if (o_mm.rsp_val) begin
            step <= step + 1'b1;
            if (step == 4'd15 || (step == 4'd7 && h_n == '0))
              state <= ADD_DONE;
            else
              state <= ADD_REQ;
          end
        end
        default: begin
          if (i_rdy)
            state <= ADD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ADD_IDLE && i_val) begin
      p1_q  <= i_p1;
      p2_q  <= i_p2;
      // Pass the finite point through when the other one is infinity
      res_q <= (i_p1.z == '0) ? i_p2 : i_p1;
    end else if (state == ADD_RSP && o_mm.rsp_val) begin
      case (step)
        4'd0: z1s <= r;
        4'd1: z2s <= r;
        4'd2: u1  <= r;
        4'd3: u2  <= r;
        4'd4: z1c <= r;
        4'd5: z2c <= r;
        4'd6: s1  <= r;
        4'd7: begin
          h  <= h_n;
          rr <= r_n;
          // Same x, opposite y gives infinity
          if (h_n == '0)
            res_q <= '0;
        end
        4'd8:  h2   <= r;
        4'd9:  h3   <= r;
        4'd10: u1h2 <= r;
        4'd11: res_q.x <= fe_sub(fe_sub(r, h3, P_MOD), fe_add(u1h2, u1h2, P_MOD), P_MOD);
        4'd12: tmp  <= r;
        4'd13: res_q.y <= fe_sub(tmp, r, P_MOD);
        4'd14: tmp  <= r;
        default: res_q.z <= r;
      endcase
    end
  end

  // Equal finite points go to the doubler, the top never sends them here
  a_no_equal_points: assert property (@(posedge i_clk) disable iff (i_rst)
    (state == ADD_RSP && o_mm.rsp_val && step == 4'd7) |-> !(h_n == '0 && r_n == '0))
    else $error("point_add received two equal finite points");

endmodule

`default_nettype wire

// ==== hw/ec_point_mult.sv ====
// Scalar point multiplication k*P on a short Weierstrass curve with a = 0
// LSB-first double-and-add with concurrent doubler and adder sharing one
// modular multiplier, plus a single add/double entry for two affine points
`timescale 1ns/1ns
`default_nettype none

module ec_point_mult
  import ec_pkg::*;
#(
  parameter int  W     = FIELD_W,
  parameter fe_t P_MOD = fe_t'(65521)
) (
  input  logic i_clk,
  input  logic i_rst,
  // Affine base point and scalar
  input  fe_t  i_x,
  input  fe_t  i_y,
  input  fe_t  i_k,
  input  logic i_val,
  output logic o_rdy,
  // Second affine point for the add-only path
  input  fe_t  i_x2,
  input  fe_t  i_y2,
  input  logic i_p2_val,
  // Jacobian result
  output fe_t  o_x,
  output fe_t  o_y,
  output fe_t  o_z,
  output logic o_val,
  input  logic i_rdy
);
  typedef enum logic [1:0] {IDLE, DOUBLE_ADD, ADD_ONLY, FINISHED} pm_state_t;

  pm_state_t state;
  fe_t       k_l;
  jpoint_t   p_in, p_in2, p_n, p_q, p_dbl, p_add, res_q;
  logic      dbl_in_val, dbl_in_rdy, dbl_out_val, dbl_done;
  logic      add_in_val, add_in_rdy, add_out_val, add_done;

  mod_mult_if mm_dbl ();
  mod_mult_if mm_add ();
  mod_mult_if mm_core ();

  assign p_in  = '{x: i_x, y: i_y, z: fe_t'(1)};
  assign p_in2 = '{x: i_x2, y: i_y2, z: fe_t'(1)};
  assign o_x   = res_q.x;
  assign o_y   = res_q.y;
  assign o_z   = res_q.z;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= IDLE;
      o_rdy      <= 1'b0;
      o_val      <= 1'b0;
      dbl_in_val <= 1'b0;
      add_in_val <= 1'b0;
      dbl_done   <= 1'b0;
      add_done   <= 1'b0;
    end else begin
      if (dbl_in_val && dbl_in_rdy)
        dbl_in_val <= 1'b0;
      if (add_in_val && add_in_rdy)
        add_in_val <= 1'b0;
      case (state)
        IDLE: begin
          o_rdy    <= 1'b1;
          dbl_done <= 1'b1;
          add_done <= 1'b1;
          if (o_rdy && i_p2_val) begin
            o_rdy <= 1'b0;
            state <= ADD_ONLY;
            // Equal points need the doubling formula
            if (i_x == i_x2 && i_y == i_y2)
              dbl_in_val <= 1'b1;
            else
              add_in_val <= 1'b1;
          end else if (o_rdy && i_val) begin
            o_rdy <= 1'b0;
            state <= DOUBLE_ADD;
          end
        end
        DOUBLE_ADD: begin
          if (dbl_out_val)
            dbl_done <= 1'b1;
          if (add_out_val)
            add_done <= 1'b1;
          if (dbl_done && add_done) begin
            if (k_l == '0) begin
              state <= FINISHED;
              o_val <= 1'b1;
            end else begin
              add_in_val <= k_l[0];
              add_done   <= ~k_l[0];
              // No doubling once the top bit is consumed
              dbl_in_val <= (k_l[FIELD_W-1:1] != '0);
              dbl_done   <= (k_l[FIELD_W-1:1] == '0);
            end
          end
        end
        ADD_ONLY: begin
          if (dbl_out_val || add_out_val) begin
            state <= FINISHED;
            o_val <= 1'b1;
          end
        end
        default: begin
          if (i_rdy) begin
            o_val <= 1'b0;
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (state)
      IDLE: begin
        p_n <= p_in;
        k_l <= i_k;
        p_q <= i_p2_val ? p_in2 : '0;
      end
      DOUBLE_ADD: begin
        if (dbl_out_val)
          p_n <= p_dbl;
        if (add_out_val)
          p_q <= p_add;
        if (dbl_done && add_done) begin
          k_l <= k_l >> 1;
          if (k_l == '0)
            res_q <= p_q;
        end
      end
      ADD_ONLY: begin
        if (dbl_out_val)
          res_q <= p_dbl;
        else if (add_out_val)
          res_q <= p_add;
      end
      default: ;
    endcase
  end

  point_dbl #(.P_MOD(P_MOD)) u_dbl (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_p   (p_n),
    .i_val (dbl_in_val),
    .o_rdy (dbl_in_rdy),
    .o_p   (p_dbl),
    .o_val (dbl_out_val),
    .i_rdy (1'b1),
    .o_mm  (mm_dbl.requester)
  );

  point_add #(.P_MOD(P_MOD)) u_add (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_p1  (p_q),
    .i_p2  (p_n),
    .i_val (add_in_val),
    .o_rdy (add_in_rdy),
    .o_p   (p_add),
    .o_val (add_out_val),
    .i_rdy (1'b1),
    .o_mm  (mm_add.requester)
  );

  mult_arbiter u_arb (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req0 (mm_dbl.server),
    .i_req1 (mm_add.server),
    .o_core (mm_core.requester)
  );

  mod_mult #(.W(W), .P_MOD(P_MOD)) u_mm (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_mm  (mm_core.server)
  );

endmodule

`default_nettype wire

// ==== verification/tb_ec_point_mult.sv ====
// Testbench for ec_point_mult
// Runs scalar multiplication and the add-only path against an affine model
// and checks the output handshake while the result is held back
`timescale 1ns/1ns
`default_nettype none

module tb_ec_point_mult
  import ec_pkg::*;
();
  localparam logic [31:0] PRIME   = 32'd65521;
  localparam int          TIMEOUT = 20000;
  localparam int          NUM_RND = 12;

  // Affine point for the reference model
  typedef struct packed {
    logic inf;
    fe_t  x;
    fe_t  y;
  } apt_t;

  logic i_clk = 1'b0;
  logic i_rst;
  fe_t  i_x, i_y, i_k, i_x2, i_y2;
  logic i_val, i_p2_val, i_rdy;
  fe_t  o_x, o_y, o_z;
  logic o_rdy, o_val;

  logic [31:0] lcg_state = 32'he3ed;
  logic        timed_out = 1'b0;
  logic        busy;
  int          checks = 0;
  int          skipped = 0;
  int          errors = 0;
  int          hold_errors = 0;
  int          ready_errors = 0;

  always #50 i_clk = ~i_clk;

  ec_point_mult u_dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_x      (i_x),
    .i_y      (i_y),
    .i_k      (i_k),
    .i_val    (i_val),
    .o_rdy    (o_rdy),
    .i_x2     (i_x2),
    .i_y2     (i_y2),
    .i_p2_val (i_p2_val),
    .o_x      (o_x),
    .o_y      (o_y),
    .o_z      (o_z),
    .o_val    (o_val),
    .i_rdy    (i_rdy)
  );

  // Operation in flight from acceptance until the result is taken
  always @(posedge i_clk) begin
    if (i_rst)
      busy <= 1'b0;
    else if (o_rdy && (i_val || i_p2_val))
      busy <= 1'b1;
    else if (o_val && i_rdy)
      busy <= 1'b0;
  end

  a_hold_result: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_x) && $stable(o_y) && $stable(o_z)))
    else begin
      hold_errors++;
      $display("error at %0t ns: result changed before it was taken", $time);
    end

  a_no_rdy_while_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    busy |-> !o_rdy)
    else begin
      ready_errors++;
      $display("error at %0t ns: o_rdy high while an operation is in flight", $time);
    end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic fe_t rand_below(int unsigned n);
    logic [31:0] v;
    v = lcg_next();
    return fe_t'(v[30:8] % n);
  endfunction

  function automatic fe_t mulm(fe_t a, fe_t b);
    return fe_t'((32'(a) * 32'(b)) % PRIME);
  endfunction

  function automatic fe_t subm(fe_t a, fe_t b);
    return fe_t'((32'(a) + PRIME - 32'(b)) % PRIME);
  endfunction

  // Fermat inverse as a^(p-2)
  function automatic fe_t invm(fe_t a);
    fe_t         r;
    fe_t         base;
    logic [31:0] e;
    r    = fe_t'(1);
    base = a;
    e    = PRIME - 32'd2;
    while (e != 0) begin
      if (e[0])
        r = mulm(r, base);
      base = mulm(base, base);
      e    = e >> 1;
    end
    return r;
  endfunction

  function automatic apt_t aff_dbl(apt_t p);
    apt_t r;
    fe_t  lam;
    if (p.inf || p.y == '0)
      return '{inf: 1'b1, x: '0, y: '0};
    lam   = mulm(mulm(fe_t'(3), mulm(p.x, p.x)), invm(mulm(fe_t'(2), p.y)));
    r.inf = 1'b0;
    r.x   = subm(mulm(lam, lam), mulm(fe_t'(2), p.x));
    r.y   = subm(mulm(lam, subm(p.x, r.x)), p.y);
    return r;
  endfunction

  function automatic apt_t aff_add(apt_t p, apt_t q);
    apt_t r;
    fe_t  lam;
    if (p.inf)
      return q;
    if (q.inf)
      return p;
    if (p.x == q.x) begin
      if (p.y == q.y)
        return aff_dbl(p);
      else
        return '{inf: 1'b1, x: '0, y: '0};
    end
    lam   = mulm(subm(q.y, p.y), invm(subm(q.x, p.x)));
    r.inf = 1'b0;
    r.x   = subm(subm(mulm(lam, lam), p.x), q.x);
    r.y   = subm(mulm(lam, subm(p.x, r.x)), p.y);
    return r;
  endfunction

  // LSB-first schedule that flags rounds where Q and N are the same finite point
  function automatic apt_t model_mult(apt_t p, fe_t k, output logic clash);
    apt_t q;
    apt_t n;
    q     = '{inf: 1'b1, x: '0, y: '0};
    n     = p;
    clash = 1'b0;
    while (k != '0) begin
      if (k[0]) begin
        if (!q.inf && !n.inf && q == n)
          clash = 1'b1;
        q = aff_add(q, n);
      end
      k = k >> 1;
      if (k != '0)
        n = aff_dbl(n);
    end
    return q;
  endfunction

  task automatic wait_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic run_op(input logic add_only, input fe_t x, input fe_t y, input fe_t x2,
                        input fe_t y2, input fe_t k, input logic stall,
                        output jpoint_t res);
    int   n;
    logic got;
    res = '0;
    if (timed_out)
      return;
    n = 0;
    while (!o_rdy && n < TIMEOUT) begin
      wait_cycle();
      n++;
    end
    if (!o_rdy) begin
      timed_out = 1'b1;
      $display("Timeout: the DUT never raised o_rdy to take a new operation");
      return;
    end
    i_x      = x;
    i_y      = y;
    i_x2     = x2;
    i_y2     = y2;
    i_k      = k;
    i_val    = !add_only;
    i_p2_val = add_only;
    wait_cycle();
    i_val    = 1'b0;
    i_p2_val = 1'b0;
    n   = 0;
    got = 1'b0;
    while (!got && n < TIMEOUT) begin
      i_rdy = stall ? (lcg_next() % 3 == 0) : 1'b1;
      if (o_val && i_rdy) begin
        res = '{x: o_x, y: o_y, z: o_z};
        got = 1'b1;
      end
      wait_cycle();
      n++;
    end
    i_rdy = 1'b1;
    if (!got) begin
      timed_out = 1'b1;
      $display("Timeout: the DUT never delivered a result on o_val");
    end
  endtask

  // Jacobian result must map onto the affine expectation
  task automatic check_result(input apt_t want, input jpoint_t got, input string what);
    fe_t z2;
    fe_t z3;
    if (timed_out)
      return;
    checks++;
    z2 = mulm(got.z, got.z);
    z3 = mulm(z2, got.z);
    if (want.inf) begin
      assert (got.z == '0)
        else begin
          errors++;
          $display("error at %0t ns: %s expected infinity, got Z=%0d", $time, what, got.z);
        end
    end else begin
      assert (got.z != '0 && got.x == mulm(want.x, z2) && got.y == mulm(want.y, z3))
        else begin
          errors++;
          $display("error at %0t ns: %s got (%0d, %0d, %0d), expected affine (%0d, %0d)",
                   $time, what, got.x, got.y, got.z, want.x, want.y);
        end
    end
  endtask

  initial begin
    fe_t     x, y, x2, y2, k;
    apt_t    pa, pb, want;
    jpoint_t res;
    logic    clash;
    i_rst    = 1'b1;
    i_x      = '0;
    i_y      = '0;
    i_k      = '0;
    i_x2     = '0;
    i_y2     = '0;
    i_val    = 1'b0;
    i_p2_val = 1'b0;
    i_rdy    = 1'b1;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    x  = rand_below(256);
    y  = fe_t'(1) + rand_below(255);
    pa = '{inf: 1'b0, x: x, y: y};
    run_op(1'b0, x, y, '0, '0, fe_t'(1), 1'b0, res);
    check_result(model_mult(pa, fe_t'(1), clash), res, "k = 1");
    if (!timed_out) begin
      checks++;
      assert (res.x == x && res.y == y && res.z == fe_t'(1))
        else begin
          errors++;
          $display("error at %0t ns: k = 1 did not return the input point", $time);
        end
    end
    run_op(1'b0, x, y, '0, '0, '0, 1'b1, res);
    check_result('{inf: 1'b1, x: '0, y: '0}, res, "k = 0");

    // Add-only path with distinct points, equal points, then P and -P
    x2 = rand_below(256);
    if (x2 == x)
      x2 = x + fe_t'(1);
    y2 = fe_t'(1) + rand_below(255);
    pb = '{inf: 1'b0, x: x2, y: y2};
    run_op(1'b1, x, y, x2, y2, '0, 1'b1, res);
    check_result(aff_add(pa, pb), res, "add of distinct points");
    run_op(1'b1, x, y, x, y, '0, 1'b0, res);
    check_result(aff_dbl(pa), res, "add of equal points");
    run_op(1'b1, x, y, x, subm('0, y), '0, 1'b1, res);
    check_result('{inf: 1'b1, x: '0, y: '0}, res, "add of P and -P");

    for (int i = 0; i < NUM_RND && !timed_out; i++) begin
      x    = rand_below(256);
      y    = fe_t'(1) + rand_below(255);
      k    = rand_below(256);
      pa   = '{inf: 1'b0, x: x, y: y};
      want = model_mult(pa, k, clash);
      if (clash) begin
        skipped++;
      end else begin
        run_op(1'b0, x, y, '0, '0, k, i[0], res);
        check_result(want, res, "random k*P");
      end
    end

    $display("Checks %0d, skipped %0d, value errors %0d, hold errors %0d, ready errors %0d",
             checks, skipped, errors, hold_errors, ready_errors);
    if (!timed_out && errors == 0 && hold_errors == 0 && ready_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/ec_pkg.sv
hw/mod_mult_if.sv
hw/mod_mult.sv
hw/mult_arbiter.sv
hw/point_dbl.sv
hw/point_add.sv
hw/ec_point_mult.sv
verification/tb_ec_point_mult.sv

// ==== Bender.yml ====
package:
  name: ec_point_mult

sources:
  - hw/ec_pkg.sv
  - hw/mod_mult_if.sv
  - hw/mod_mult.sv
  - hw/mult_arbiter.sv
  - hw/point_dbl.sv
  - hw/point_add.sv
  - hw/ec_point_mult.sv
  - target: test
    files:
      - verification/tb_ec_point_mult.sv

# Simulation top: tb_ec_point_mult
# Synthesis top: ec_point_mult
